//--- sdram_sub.f
design/sdram_pkg.sv
design/sdram_req_arbiter.sv
design/sdram_req_queue.sv
design/sdram_ctrl.sv
design/sdram_sub_top.sv
dv/sdram_model.sv
dv/sdram_checker.sv
dv/tb_sdram_sub.sv

//--- dv/sdram_sub_tests.txt
# id op addr data exp  (hex; op W write, R read expecting exp, P paired streams of exp requests)
# B burst of addr random requests, I idle for addr cycles
1 W 0000000 3c 00
1 R 0000000 00 3c
2 W 0801403 a1 00
2 W 1001403 b2 00
2 W 0801803 c3 00
2 W 0801404 d4 00
2 R 0801404 00 d4
2 R 0801803 00 c3
2 R 1001403 00 b2
2 R 0801403 00 a1
3 P 0002000 40 0c
4 I 0000258 00 00
4 W 1802c05 5e 00
4 R 1802c05 00 5e
5 P 0004000 80 10
5 I 0000200 00 00
5 P 0006000 20 18
6 B 000003c 00 00
6 R 0801404 00 d4
6 B 0000028 00 00

//--- dv/tb_sdram_sub.sv
module tb_sdram_sub import sdram_pkg::*; ();

    logic                     clk;
    logic                     rst_n;
    logic                     wr_valid;
    logic                     wr_ready;
    logic [HADDR_WIDTH-1:0]   wr_addr;
    logic [DATA_WIDTH-1:0]    wr_data;
    logic                     rd_valid;
    logic                     rd_ready;
    logic [HADDR_WIDTH-1:0]   rd_addr;
    logic                     rsp_valid;
    logic [DATA_WIDTH-1:0]    rsp_data;
    logic                     init_done;
    logic                     sdram_cke;
    logic                     sdram_cs_n;
    logic                     sdram_ras_n;
    logic                     sdram_cas_n;
    logic                     sdram_we_n;
    logic [BANK_WIDTH-1:0]    sdram_ba;
    logic [SDRADDR_WIDTH-1:0] sdram_addr;
    logic                     sdram_dqm;
    wire  [DATA_WIDTH-1:0]    sdram_dq;

    // Read expectation source travels with the read request
    logic                     rd_use_file;
    logic [DATA_WIDTH-1:0]    rd_exp;
    logic [DATA_WIDTH-1:0]    refm [int];
    logic [7:0]               lfsr_state = 8'd62;

    int          nrec = 0;
    int          rec_id [$];
    logic [7:0]  rec_op [$];
    logic [31:0] rec_addr [$];
    logic [31:0] rec_data [$];
    logic [31:0] rec_exp [$];

    sdram_sub_top i_sdram_sub_top (.*);

    sdram_model i_model (
        .clk   (clk),
        .rst_n (rst_n),
        .cke   (sdram_cke),
        .cs_n  (sdram_cs_n),
        .ras_n (sdram_ras_n),
        .cas_n (sdram_cas_n),
        .we_n  (sdram_we_n),
        .ba    (sdram_ba),
        .addr  (sdram_addr),
        .dqm   (sdram_dqm),
        .dq    (sdram_dq)
    );

    sdram_checker i_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .init_done     (init_done),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .proto_errors  (i_model.errors),
        .refresh_count (i_model.refreshes)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    // Fibonacci LFSR x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
        lfsr_state = {lfsr_state[6:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] fill(input logic [HADDR_WIDTH-1:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'b0, a[24]};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] ref_read(input logic [HADDR_WIDTH-1:0] a);
        return refm.exists(int'(a)) ? refm[int'(a)] : fill(a);
    endfunction

    // Reference memory follows the handshakes in acceptance order
    always @(posedge clk)
    begin
        if (rst_n && wr_valid && wr_ready)
            refm[int'(wr_addr)] = wr_data;
        if (rst_n && rd_valid && rd_ready)
            i_checker.add_expect(rd_use_file ? rd_exp : ref_read(rd_addr));
    end

    task automatic load_tests();
        int fd;
        int n;
        int id;
        string line;
        logic [7:0] op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("dv/sdram_sub_tests.txt", "r");
        if (fd == 0)
            $display("ERROR: cannot open dv/sdram_sub_tests.txt");
        else
        begin
            while (!$feof(fd))
            begin
                if ($fgets(line, fd) && line.len() > 0 && line[0] != "#")
                begin
                    n = $sscanf(line, "%d %s %h %h %h", id, op, a, d, e);
                    if (n == 5)
                    begin
                        rec_id.push_back(id);
                        rec_op.push_back(op);
                        rec_addr.push_back(a);
                        rec_data.push_back(d);
                        rec_exp.push_back(e);
                    end
                end
            end
            $fclose(fd);
            nrec = rec_id.size();
        end
    endtask

    task automatic send_write(input logic [HADDR_WIDTH-1:0] a, input logic [7:0] d);
        @(posedge clk);
        wr_valid <= 1'b1;
        wr_addr  <= a;
        wr_data  <= d;
        do
            @(posedge clk);
        while (!wr_ready);
        wr_valid <= 1'b0;
    endtask

    task automatic send_read(input logic [HADDR_WIDTH-1:0] a, input logic use_file,
                             input logic [7:0] e);
        @(posedge clk);
        rd_valid    <= 1'b1;
        rd_addr     <= a;
        rd_use_file <= use_file;
        rd_exp      <= e;
        do
            @(posedge clk);
        while (!rd_ready);
        rd_valid <= 1'b0;
    endtask

    // Both ports held valid so the arbiter alternates and the queue fills
    task automatic send_pair(input logic [HADDR_WIDTH-1:0] base, input logic [7:0] d,
                             input int n);
        int wi;
        int ri;
        wi = 0;
        ri = 0;
        @(posedge clk);
        wr_valid    <= 1'b1;
        wr_addr     <= base;
        wr_data     <= d;
        rd_valid    <= 1'b1;
        rd_addr     <= base;
        rd_use_file <= 1'b0;
        while (wi < n || ri < n)
        begin
            @(posedge clk);
            if (wr_valid && wr_ready)
            begin
                wi++;
                wr_addr  <= base + wi;
                wr_data  <= d + wi;
                wr_valid <= (wi < n);
            end
            if (rd_valid && rd_ready)
            begin
                ri++;
                rd_addr  <= base + ri;
                rd_valid <= (ri < n);
            end
        end
    endtask

    task automatic run_burst(input int n);
        logic [HADDR_WIDTH-1:0] a;
        logic [5:0] r;
        logic is_wr;
        logic [7:0] d;
        int gap;
        for (int k = 0; k < n; k++)
        begin
            is_wr = rand_bits(1);
            r     = rand_bits(6);
            d     = rand_bits(8);
            gap   = rand_bits(2);
            // Two bits each of bank, row and column
            a = '0;
            a[24:23] = r[5:4];
            a[11:10] = r[3:2];
            a[1:0]   = r[1:0];
            if (is_wr)
                send_write(a, d);
            else
                send_read(a, 1'b0, 8'h00);
            repeat (gap)
                @(posedge clk);
        end
    endtask

    task automatic finish_test(input int id);
        // The last read handshake lands in the expectation list on this edge
        @(posedge clk);
        while (i_checker.pending != 0)
            @(posedge clk);
        repeat (2)
            @(posedge clk);
        i_checker.report_test(id);
    endtask

    initial
    begin
        rst_n       = 1'b0;
        wr_valid    = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        rd_valid    = 1'b0;
        rd_addr     = '0;
        rd_use_file = 1'b0;
        rd_exp      = '0;
        load_tests();
        repeat (8)
            @(posedge clk);
        rst_n <= 1'b1;
        while (!init_done)
            @(posedge clk);
        for (int i = 0; i < nrec; i++)
        begin
            case (rec_op[i])
                "W": send_write(rec_addr[i], rec_data[i]);
                "R": send_read(rec_addr[i], 1'b1, rec_exp[i]);
                "P": send_pair(rec_addr[i], rec_data[i], rec_exp[i]);
                "B": run_burst(rec_addr[i]);
                "I": repeat (rec_addr[i]) @(posedge clk);
                default: $display("ERROR: unknown operation in record %0d", i);
            endcase
            if (i == nrec - 1 || rec_id[i + 1] != rec_id[i])
                finish_test(rec_id[i]);
        end
        repeat (10)
            @(posedge clk);
        i_checker.report_final();
        if (nrec == 0 || i_checker.total_errors() != 0)
            $display("*** FAILED ***");
        else
            $display("*** PASSED ***");
        $finish;
    end

    initial
    begin
        wait (nrec > 0);
        repeat (nrec * 2 * REFRESH_INTERVAL + 100)
            @(posedge clk);
        $display("ERROR: timeout, tests still running after %0d cycles",
                 nrec * 2 * REFRESH_INTERVAL + 100);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- dv/sdram_checker.sv
module sdram_checker import sdram_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  init_done,
    input  logic                  wr_valid,
    input  logic                  wr_ready,
    input  logic                  rd_valid,
    input  logic                  rd_ready,
    input  logic                  rsp_valid,
    input  logic [DATA_WIDTH-1:0] rsp_data,
    input  int                    proto_errors,
    input  int                    refresh_count
);

    logic [DATA_WIDTH-1:0] exp_q [$];
    int   pending = 0;
    int   errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   errors_before = 0;
    logic init_seen;
    logic last_known;
    logic last_wr;
    logic both_prev;

    // Filled by the testbench at each read handshake, in arbitration order
    task automatic add_expect(input logic [DATA_WIDTH-1:0] value);
        exp_q.push_back(value);
        pending = exp_q.size();
    endtask

    always @(posedge clk)
    begin
        logic [DATA_WIDTH-1:0] expected;
        if (!rst_n)
        begin
            init_seen  = 1'b0;
            last_known = 1'b0;
            both_prev  = 1'b0;
        end
        else
        begin
            if (init_seen && !init_done)
            begin
                $display("ERROR at %0t: init_done fell after rising", $time);
                errors++;
            end
            init_seen = init_seen || init_done;
            if ((wr_valid && wr_ready) || (rd_valid && rd_ready))
            begin
                // With both ports waiting, the loser of the last grant wins
                if (both_prev && wr_valid && rd_valid && last_known && wr_ready == last_wr)
                begin
                    $display("ERROR at %0t: arbiter granted the same port twice", $time);
                    errors++;
                end
                last_wr    = wr_ready;
                last_known = 1'b1;
            end
            both_prev = wr_valid && rd_valid;
            if (rsp_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("ERROR at %0t: read response with no read outstanding", $time);
                    errors++;
                end
                else
                begin
                    expected = exp_q.pop_front();
                    pending  = exp_q.size();
                    if (rsp_data !== expected)
                    begin
                        $display("MISMATCH at %0t: rsp_data expected %02h got %02h",
                                 $time, expected, rsp_data);
                        errors++;
                    end
                end
            end
        end
    end

    task automatic report_test(input int id);
        int total;
        total = errors + proto_errors;
        tests_run++;
        if (total != errors_before)
            tests_failed++;
        $display("test %0d %s, %0d errors", id,
                 (total != errors_before) ? "failed" : "ok", total - errors_before);
        errors_before = total;
    endtask

    task automatic report_final();
        if (exp_q.size() != 0)
        begin
            $display("ERROR at %0t: %0d read responses never arrived", $time, exp_q.size());
            errors++;
        end
        $display("%0d tests, %0d failed, %0d errors, %0d refreshes seen", tests_run,
                 tests_failed, errors + proto_errors, refresh_count);
    endtask

    function automatic int total_errors();
        return errors + proto_errors;
    endfunction

endmodule

//--- dv/sdram_model.sv
module sdram_model import sdram_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     cke,
    input  logic                     cs_n,
    input  logic                     ras_n,
    input  logic                     cas_n,
    input  logic                     we_n,
    input  logic [BANK_WIDTH-1:0]    ba,
    input  logic [SDRADDR_WIDTH-1:0] addr,
    input  logic                     dqm,
    inout  wire  [DATA_WIDTH-1:0]    dq
);

    logic [DATA_WIDTH-1:0]  mem [int];
    logic [3:0]             cmd;
    logic                   bank_open [4];
    logic [ROW_WIDTH-1:0]   open_row [4];
    int                     act_cyc [4];
    int                     errors = 0;
    int                     refreshes = 0;
    int                     cycle;
    int                     init_step;
    int                     last_cmd_cyc;
    int                     last_ref_cyc;
    logic                   rd_pend;
    logic [DATA_WIDTH-1:0]  rd_val;
    logic                   drive_en = 1'b0;
    logic [DATA_WIDTH-1:0]  drive_data;
    logic [3:0]             init_seq [4];
    int                     init_gap [4];

    assign cmd = {cs_n, ras_n, cas_n, we_n};
    assign dq  = drive_en ? drive_data : {DATA_WIDTH{1'bz}};

    initial
    begin
        init_seq = '{CMD_PALL, CMD_REF, CMD_REF, CMD_MRS};
        init_gap = '{0, T_RP, T_RC, T_RC};
    end

    // Unwritten locations read back a value folded from the whole address
    function automatic logic [DATA_WIDTH-1:0] fill(input logic [HADDR_WIDTH-1:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'b0, a[24]};
    endfunction

    task automatic violation(input string msg);
        $display("ERROR at %0t: SDRAM protocol violation, %s", $time, msg);
        errors++;
    endtask

    always @(posedge clk)
    begin
        logic [HADDR_WIDTH-1:0] key;
        int gap;
        if (!rst_n)
        begin
            cycle     = 0;
            init_step = 0;
            rd_pend  <= 1'b0;
            drive_en <= 1'b0;
            for (int b = 0; b < 4; b++)
                bank_open[b] = 1'b0;
        end
        else
        begin
            cycle++;
            // CAS latency 2: data sits on the bus in the second cycle after READ
            drive_en   <= rd_pend;
            drive_data <= rd_val;
            rd_pend    <= 1'b0;
            key = {ba, open_row[ba], addr[COL_WIDTH-1:0]};
            if (cke !== 1'b1)
                violation("clock enable dropped");
            if (init_step < 4)
            begin
                if (cmd != CMD_NOP)
                begin
                    gap = cycle - last_cmd_cyc;
                    if (cmd != init_seq[init_step])
                        violation("power-up command out of order");
                    else if (init_step > 0 && gap < init_gap[init_step])
                        violation("power-up wait too short");
                    else if (cmd == CMD_PALL && !addr[10])
                        violation("precharge without A10");
                    else if (cmd == CMD_MRS && addr != MODE_REG)
                        violation("mode register word is wrong");
                    last_cmd_cyc = cycle;
                    last_ref_cyc = cycle;
                    init_step++;
                end
            end
            else
            begin
                // Flagged once, as soon as a refresh is overdue
                if (cycle - last_ref_cyc == REFRESH_INTERVAL + LONGEST_OP + 1)
                    violation("refresh came too late");
                case (cmd)
                    CMD_NOP: ;
                    CMD_REF:
                    begin
                        if (bank_open[0] || bank_open[1] || bank_open[2] || bank_open[3])
                            violation("refresh with a bank still open");
                        refreshes++;
                        last_ref_cyc = cycle;
                    end
                    CMD_ACT:
                    begin
                        if (bank_open[ba])
                            violation("activate on an open bank");
                        bank_open[ba] = 1'b1;
                        open_row[ba]  = addr[ROW_WIDTH-1:0];
                        act_cyc[ba]   = cycle;
                    end
                    CMD_READ,
                    CMD_WRITE:
                    begin
                        if (!bank_open[ba])
                            violation("column access to a closed bank");
                        if (cycle - act_cyc[ba] < T_RCD)
                            violation("column access before tRCD");
                        if (!addr[10])
                            violation("column access without auto-precharge");
                        if (cmd == CMD_WRITE)
                        begin
                            if (dqm)
                                violation("write with the data mask set");
                            else
                                mem[int'(key)] = dq;
                        end
                        else
                        begin
                            rd_pend <= 1'b1;
                            rd_val  <= mem.exists(int'(key)) ? mem[int'(key)] : fill(key);
                        end
                        bank_open[ba] = 1'b0;
                    end
                    default:
                        violation("unexpected command after power-up");
                endcase
            end
        end
    end

endmodule

//--- design/sdram_sub_top.sv
module sdram_sub_top import sdram_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     wr_valid,
    output logic                     wr_ready,
    input  logic [HADDR_WIDTH-1:0]   wr_addr,
    input  logic [DATA_WIDTH-1:0]    wr_data,

    input  logic                     rd_valid,
    output logic                     rd_ready,
    input  logic [HADDR_WIDTH-1:0]   rd_addr,

    output logic                     rsp_valid,
    output logic [DATA_WIDTH-1:0]    rsp_data,
    output logic                     init_done,

    output logic                     sdram_cke,
    output logic                     sdram_cs_n,
    output logic                     sdram_ras_n,
    output logic                     sdram_cas_n,
    output logic                     sdram_we_n,
    output logic [BANK_WIDTH-1:0]    sdram_ba,
    output logic [SDRADDR_WIDTH-1:0] sdram_addr,
    output logic                     sdram_dqm,
    inout  wire  [DATA_WIDTH-1:0]    sdram_dq
);

    // Merged host requests into the queue
    logic       req_valid;
    logic       req_ready;
    sdram_req_t req;

    // Queue head towards the controller
    logic       q_valid;
    logic       q_ready;
    sdram_req_t q_req;

    sdram_req_arbiter i_arbiter (.*);

    sdram_req_queue i_queue (.*);

    sdram_ctrl i_ctrl (.*);

endmodule

//--- design/sdram_ctrl.sv
module sdram_ctrl import sdram_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     q_valid,
    input  sdram_req_t               q_req,
    output logic                     q_ready,

    output logic                     rsp_valid,
    output logic [DATA_WIDTH-1:0]    rsp_data,
    output logic                     init_done,

    output logic                     sdram_cke,
    output logic                     sdram_cs_n,
    output logic                     sdram_ras_n,
    output logic                     sdram_cas_n,
    output logic                     sdram_we_n,
    output logic [BANK_WIDTH-1:0]    sdram_ba,
    output logic [SDRADDR_WIDTH-1:0] sdram_addr,
    output logic                     sdram_dqm,
    inout  wire  [DATA_WIDTH-1:0]    sdram_dq
);

    typedef enum logic [3:0] {
        S_INIT_WAIT,
        S_INIT_PALL,
        S_INIT_REF1,
        S_INIT_REF2,
        S_INIT_MRS,
        S_IDLE,
        S_REF,
        S_ACT,
        S_READ,
        S_WRITE
    } state_e;

    state_e                   state;
    sdram_cmd_e               cmd;
    logic [WAIT_WIDTH-1:0]    wait_cnt;
    logic                     wait_done;
    logic [REF_CNT_WIDTH-1:0] ref_cnt;
    logic                     ref_due;
    logic                     pop;
    logic                     dq_oe;
    logic [CAS_LATENCY-1:0]   rd_pipe;
    sdram_req_t               req_r;
    logic [SDRADDR_WIDTH-1:0] col_addr;

    assign wait_done = (wait_cnt == '0);
    assign ref_due   = (ref_cnt >= REF_CNT_WIDTH'(REFRESH_INTERVAL));
    assign q_ready   = (state == S_IDLE) && !ref_due;
    assign pop       = q_valid && q_ready;

    // A10 set selects auto-precharge
    assign col_addr = {{(SDRADDR_WIDTH - COL_WIDTH - 1){1'b0}}, 1'b1, req_r.addr[COL_WIDTH-1:0]};

    // Power-down is never used
    assign sdram_cke = 1'b1;
    assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd;
    assign sdram_dq  = dq_oe ? req_r.data : {DATA_WIDTH{1'bz}};

    always_ff @(posedge clk)
    begin
        if (pop)
            req_r <= q_req;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= S_INIT_WAIT;
            wait_cnt   <= WAIT_WIDTH'(T_INIT - 1);
            cmd        <= CMD_NOP;
            sdram_ba   <= '0;
            sdram_addr <= '0;
            sdram_dqm  <= 1'b1;
            dq_oe      <= 1'b0;
            init_done  <= 1'b0;
        end
        else
        begin
            cmd   <= CMD_NOP;
            dq_oe <= 1'b0;
            if (!wait_done)
                wait_cnt <= wait_cnt - 1'b1;

            case (state)
                S_INIT_WAIT:
                    if (wait_done)
                    begin
                        // Precharge all banks
                        cmd        <= CMD_PALL;
                        sdram_addr <= SDRADDR_WIDTH'(1 << 10);
                        wait_cnt   <= WAIT_WIDTH'(T_RP - 1);
                        state      <= S_INIT_PALL;
                    end
                S_INIT_PALL:
                    if (wait_done)
                    begin
                        cmd      <= CMD_REF;
                        wait_cnt <= WAIT_WIDTH'(T_RC - 1);
                        state    <= S_INIT_REF1;
                    end
                S_INIT_REF1:
                    if (wait_done)
                    begin
                        cmd      <= CMD_REF;
                        wait_cnt <= WAIT_WIDTH'(T_RC - 1);
                        state    <= S_INIT_REF2;
                    end
                S_INIT_REF2:
                    if (wait_done)
                    begin
                        cmd        <= CMD_MRS;
                        sdram_ba   <= '0;
                        sdram_addr <= MODE_REG;
                        wait_cnt   <= WAIT_WIDTH'(T_MRD - 1);
                        state      <= S_INIT_MRS;
                    end
                S_INIT_MRS:
                    if (wait_done)
                    begin
                        init_done <= 1'b1;
                        state     <= S_IDLE;
                    end
                S_IDLE:
                    if (ref_due)
                    begin
                        cmd      <= CMD_REF;
                        wait_cnt <= WAIT_WIDTH'(T_RC - 1);
                        state    <= S_REF;
                    end
                    else if (pop)
                    begin
                        // Open the row straight from the queue head
                        cmd        <= CMD_ACT;
                        sdram_ba   <= q_req.addr[HADDR_WIDTH-1 -: BANK_WIDTH];
                        sdram_addr <= SDRADDR_WIDTH'(q_req.addr[COL_WIDTH +: ROW_WIDTH]);
                        sdram_dqm  <= 1'b0;
                        wait_cnt   <= WAIT_WIDTH'(T_RCD - 1);
                        state      <= S_ACT;
                    end
                S_REF:
                    if (wait_done)
                        state <= S_IDLE;
                S_ACT:
                    if (wait_done)
                    begin
                        sdram_addr <= col_addr;
                        if (req_r.write)
                        begin
                            cmd      <= CMD_WRITE;
                            dq_oe    <= 1'b1;
                            wait_cnt <= WAIT_WIDTH'(T_WR + T_RP - 1);
                            state    <= S_WRITE;
                        end
                        else
                        begin
                            cmd      <= CMD_READ;
                            wait_cnt <= WAIT_WIDTH'(CAS_LATENCY + T_RP - 1);
                            state    <= S_READ;
                        end
                    end
                S_READ,
                S_WRITE:
                    // Auto-precharge runs during this wait
                    if (wait_done)
                    begin
                        sdram_dqm <= 1'b1;
                        state     <= S_IDLE;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ref_cnt <= '0;
        else if (state == S_REF && wait_done)
            ref_cnt <= '0;
        else
            ref_cnt <= ref_cnt + 1'b1;
    end

    // Read data arrives CAS_LATENCY cycles after the READ command
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_pipe   <= '0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rd_pipe   <= {rd_pipe[CAS_LATENCY-2:0], cmd == CMD_READ};
            rsp_valid <= rd_pipe[CAS_LATENCY-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_pipe[CAS_LATENCY-1])
            rsp_data <= sdram_dq;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (cmd == CMD_ACT) |-> ($past(state) == S_IDLE));

    assert property (@(posedge clk) disable iff (!rst_n)
        dq_oe == (cmd == CMD_WRITE));

    assert property (@(posedge clk) disable iff (!rst_n)
        ref_cnt <= REF_CNT_WIDTH'(REFRESH_INTERVAL + LONGEST_OP));

endmodule

//--- design/sdram_req_queue.sv
module sdram_req_queue import sdram_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       req_valid,
    input  sdram_req_t req,
    output logic       req_ready,

    output logic       q_valid,
    output sdram_req_t q_req,
    input  logic       q_ready
);

    sdram_req_t            mem [QUEUE_DEPTH];
    logic [QPTR_WIDTH-1:0] wr_ptr;
    logic [QPTR_WIDTH-1:0] rd_ptr;
    logic [QCNT_WIDTH-1:0] count;
    logic                  push;
    logic                  pop;

    assign req_ready = (count != QCNT_WIDTH'(QUEUE_DEPTH));
    assign q_valid   = (count != '0);
    assign q_req     = mem[rd_ptr];

    assign push = req_valid && req_ready;
    assign pop  = q_valid && q_ready;

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= req;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == QPTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == QPTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) count <= QCNT_WIDTH'(QUEUE_DEPTH));

    // Head entry may not move under a stalled consumer
    assert property (@(posedge clk) disable iff (!rst_n)
        (q_valid && !q_ready) |=> (q_valid && $stable(q_req)));

endmodule

//--- design/sdram_req_arbiter.sv
module sdram_req_arbiter import sdram_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  logic [HADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0]  wr_data,

    input  logic                   rd_valid,
    output logic                   rd_ready,
    input  logic [HADDR_WIDTH-1:0] rd_addr,

    output logic                   req_valid,
    output sdram_req_t             req,
    input  logic                   req_ready
);

    logic last_wr;
    // Grant is frozen while the queue stalls so the request stays stable
    logic hold_valid;
    logic hold_wr;
    logic grant_wr;
    logic grant_rd;

    always_comb
    begin
        if (hold_valid)
            grant_wr = hold_wr;
        else if (wr_valid && rd_valid)
            grant_wr = !last_wr;
        else
            grant_wr = wr_valid;
        grant_rd = rd_valid && !grant_wr;
    end

    assign req_valid  = wr_valid || rd_valid;
    assign req.write  = grant_wr;
    assign req.addr   = grant_wr ? wr_addr : rd_addr;
    assign req.data   = grant_wr ? wr_data : '0;

    assign wr_ready = grant_wr && req_ready;
    assign rd_ready = grant_rd && req_ready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            last_wr    <= 1'b0;
            hold_valid <= 1'b0;
            hold_wr    <= 1'b0;
        end
        else
        begin
            hold_valid <= req_valid && !req_ready;
            hold_wr    <= grant_wr;
            if (req_valid && req_ready)
                last_wr <= grant_wr;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(wr_ready && rd_ready));

endmodule

//--- design/sdram_pkg.sv
package sdram_pkg;

    // Device geometry
    localparam int ROW_WIDTH     = 13;
    localparam int COL_WIDTH     = 10;
    localparam int BANK_WIDTH    = 2;
    localparam int SDRADDR_WIDTH = (ROW_WIDTH > COL_WIDTH) ? ROW_WIDTH : COL_WIDTH;
    // Host address is {bank, row, column}
    localparam int HADDR_WIDTH   = BANK_WIDTH + ROW_WIDTH + COL_WIDTH;
    localparam int DATA_WIDTH    = 8;

    // Refresh budget
    localparam int CLK_FREQ_MHZ     = 120;
    localparam int REFRESH_MS       = 32;
    localparam int REFRESH_COUNT    = 8192;
    localparam int REFRESH_INTERVAL = (CLK_FREQ_MHZ * 1000 * REFRESH_MS) / REFRESH_COUNT;

    // Cycles from a command to the next one
    localparam int T_INIT      = 16;
    localparam int T_RP        = 2;
    localparam int T_RCD       = 2;
    localparam int T_RC        = 8;
    localparam int T_MRD       = 2;
    localparam int T_WR        = 2;
    localparam int CAS_LATENCY = 2;

    // Due refresh held back by one request in flight, plus the refresh itself
    localparam int LONGEST_OP = 1 + T_RCD + CAS_LATENCY + T_RP + T_RC;

    // Burst length 1, sequential, CAS latency 2, single-location write
    localparam logic [SDRADDR_WIDTH-1:0] MODE_REG = {3'b000, 1'b1, 2'b00, 3'b010, 1'b0, 3'b000};

    localparam int QUEUE_DEPTH   = 4;
    localparam int QPTR_WIDTH    = $clog2(QUEUE_DEPTH);
    localparam int QCNT_WIDTH    = $clog2(QUEUE_DEPTH + 1);
    localparam int WAIT_WIDTH    = 5;
    localparam int REF_CNT_WIDTH = $clog2(REFRESH_INTERVAL + LONGEST_OP + 1);

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_NOP   = 4'b0111,
        CMD_PALL  = 4'b0010,
        CMD_REF   = 4'b0001,
        CMD_MRS   = 4'b0000,
        CMD_ACT   = 4'b0011,
        CMD_READ  = 4'b0101,
        CMD_WRITE = 4'b0100
    } sdram_cmd_e;

    typedef struct packed {
        logic                   write;
        logic [HADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]  data;
    } sdram_req_t;

endpackage
